/* hdl/usb_pkg.sv */
package usb_pkg;

   // 4-bit PID as it appears in the low nibble of the PID byte
   typedef enum logic [3:0] {
      RESERVED = 4'b0000,
      OUT      = 4'b0001,                 // Token
      IN       = 4'b1001,                 // Token
      SETUP    = 4'b1101,                 // Token
      DATA0    = 4'b0011,                 // Data
      DATA1    = 4'b1011,                 // Data
      ACK      = 4'b0010,                 // Handshake
      NAK      = 4'b1010,                 // Handshake
      STALL    = 4'b1110                  // Handshake
   } pid_t;

   typedef enum logic [1:0] {
      CFG_SET_ADDR  = 2'd0,               // Load device address
      CFG_SET_STALL = 2'd1,               // Halt one endpoint
      CFG_CLR_STALL = 2'd2                // Release one endpoint
   } cfg_op_t;

   // Received token, 24 bits
   typedef struct packed {
      pid_t       pid;
      logic [3:0] pidx;                   // Complement of pid
      logic [6:0] addr;
      logic [3:0] endp;
      logic [4:0] crc5;
   } token_t;

   typedef struct packed {
      logic       valid;                  // Byte strobe
      logic       active;                 // Low outside a packet
      logic [7:0] data;
   } utmi_rx_t;

   typedef struct packed {
      logic       valid;                  // Held until tx_ready
      logic [7:0] data;
   } utmi_tx_t;

   // Polynomials and residuals in reflected form since the LSB goes first
   localparam logic [4:0]  CRC5_POLY      = 5'b10100;
   localparam logic [4:0]  CRC5_RESIDUAL  = 5'b00110;
   localparam logic [15:0] CRC16_POLY     = 16'hA001;
   localparam logic [15:0] CRC16_RESIDUAL = 16'hB001;

   // Runs over addr, endp and the received crc5 bits
   function automatic logic crc5_ok(input logic [15:0] d);
      logic [4:0] crc;
      crc = 5'h1f;                        // Preset to all ones
      for (int i = 0; i < 16; i++)
      begin
         if (crc[0] ^ d[i])
            crc = (crc >> 1) ^ CRC5_POLY;
         else
            crc = crc >> 1;
      end
      return crc == CRC5_RESIDUAL;
   endfunction

   // One byte, LSB first
   function automatic logic [15:0] crc16_step(input logic [15:0] crc, input logic [7:0] d);
      logic [15:0] c;
      c = crc;
      for (int i = 0; i < 8; i++)
      begin
         if (c[0] ^ d[i])
            c = (c >> 1) ^ CRC16_POLY;
         else
            c = c >> 1;
      end
      return c;
   endfunction

endpackage

/* hdl/usb_endp_fifo.sv */
`timescale 1ns/1ps

module usb_endp_fifo #(
   parameter int DEPTH = 64               // Power of two
) (
   input  logic       clk,
   input  logic       rst,
   input  logic       clr,                // Bus reset flush
   input  logic       wr,
   input  logic       commit,
   input  logic       abort,
   input  logic [7:0] din,
   input  logic       rd,
   output logic [7:0] q,
   output logic       empty,
   output logic       full
);

   localparam int AW = $clog2(DEPTH);

   logic [7:0]  mem [DEPTH];
   logic [AW:0] rd_ptr;                   // Extra bit tells full from empty
   logic [AW:0] wr_ptr;                   // Working pointer
   logic [AW:0] cm_ptr;                   // Last committed pointer
   logic [AW:0] wr_next;
   logic        do_wr;
   logic        do_rd;

   assign empty   = (rd_ptr == cm_ptr);   // Reader sees committed data only
   assign full    = (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]) && (wr_ptr[AW] != rd_ptr[AW]);
   assign do_wr   = wr && !full;
   assign do_rd   = rd && !empty;
   assign wr_next = do_wr ? wr_ptr + 1'b1 : wr_ptr;

   always_ff @(posedge clk)
   begin
      if (rst || clr)
      begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         cm_ptr <= '0;
      end
      else
      begin
         if (abort)
            wr_ptr <= cm_ptr;             // Roll back the tentative bytes
         else
         begin
            wr_ptr <= wr_next;
            if (commit)
               cm_ptr <= wr_next;         // Includes a write in this cycle
         end
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // Storage and read port
   always_ff @(posedge clk)
   begin
      if (do_wr)
         mem[wr_ptr[AW-1:0]] <= din;
      if (do_rd)
         q <= mem[rd_ptr[AW-1:0]];        // Valid the cycle after rd
   end

endmodule

/* hdl/usb_dev_regs.sv */
`timescale 1ns/1ps

module usb_dev_regs (
   input  logic              clk,
   input  logic              rst,
   input  logic              usb_reset,
   input  logic              cfg_req,
   input  usb_pkg::cfg_op_t  cfg_op,
   input  logic              cfg_ep,     // Endpoint number for stall ops
   input  logic [6:0]        cfg_data,   // New address
   output logic              cfg_ack,
   output logic [6:0]        dev_addr,
   output logic [1:0]        stall       // One bit per endpoint
);

   typedef enum logic {
      S_IDLE,                             // Waiting for req
      S_ACK                               // Holding ack until req drops
   } state_t;

   state_t state;
   logic   apply;

   assign apply   = (state == S_IDLE) && cfg_req;   // Request edge
   assign cfg_ack = (state == S_ACK);

   // Four-phase handshake
   always_ff @(posedge clk)
   begin
      if (rst)
         state <= S_IDLE;
      else
      begin
         case (state)
            S_IDLE:
               if (cfg_req)
                  state <= S_ACK;
            S_ACK:
               if (!cfg_req)
                  state <= S_IDLE;        // Ack falls one cycle later
            default:
               state <= S_IDLE;
         endcase
      end
   end

   // Registers change on the same edge that raises ack
   always_ff @(posedge clk)
   begin
      if (rst || usb_reset)
      begin
         dev_addr <= 7'd0;                // Default address after bus reset
         stall    <= 2'b00;
      end
      else if (apply)
      begin
         case (cfg_op)
            usb_pkg::CFG_SET_ADDR:
               dev_addr <= cfg_data;
            usb_pkg::CFG_SET_STALL:
               stall[cfg_ep] <= 1'b1;
            usb_pkg::CFG_CLR_STALL:
               stall[cfg_ep] <= 1'b0;
            default:
               ;                          // Unused code is a no-op
         endcase
      end
   end

endmodule

/* hdl/usb_sie.sv */
`timescale 1ns/1ps

module usb_sie (
   input  logic              clk,
   input  logic              rst,
   input  logic              usb_reset,
   input  usb_pkg::utmi_rx_t rx,
   output usb_pkg::utmi_tx_t tx,
   input  logic              tx_ready,
   input  logic [6:0]        dev_addr,
   input  logic [1:0]        stall,
   input  logic              ep0o_full,
   output logic              ep0o_wr,
   output logic              ep0o_commit,
   output logic              ep0o_abort,
   output logic [7:0]        ep0o_din,
   input  logic [1:0]        epi_empty,
   input  logic [7:0]        epi_q0,
   input  logic [7:0]        epi_q1,
   output logic [1:0]        epi_rd
);

   typedef enum logic [3:0] {
      S_TOKEN0,                           // Idle, waiting for a PID byte
      S_TOKEN1,                           // Addr and endp[0]
      S_TOKEN2,                           // endp[3:1] and crc5
      S_TOKEN3,                           // Wait for end of token
      S_SKIP,                             // Drop rest of a foreign packet
      S_OUT_PID,
      S_OUT_DATA,
      S_IN_PID,
      S_IN_DATA,
      S_IN_CRC0,
      S_IN_CRC1,
      S_ACK,
      S_STALL
   } state_t;

   state_t            state;
   state_t            state_next;
   usb_pkg::token_t   token;
   usb_pkg::pid_t     rx_pid;
   logic [15:0]       crc;
   logic [7:0]        hold0;              // Newest OUT byte
   logic [7:0]        hold1;              // Byte to write next
   logic [1:0]        held;               // Bytes in the delay line
   logic              tok_ok;
   logic              tok_pid;
   logic              data_pid_ok;
   logic              stalled;
   logic              ep_sel;
   logic              in_empty;
   logic [7:0]        in_q;
   logic              in_rd;
   logic              rx_end;
   logic              crc_good;

   assign rx_pid   = usb_pkg::pid_t'(rx.data[3:0]);
   assign rx_end   = !rx.valid && !rx.active;
   assign crc_good = (crc == usb_pkg::CRC16_RESIDUAL);
   assign tok_pid  = (rx_pid == usb_pkg::OUT) || (rx_pid == usb_pkg::IN) ||
                     (rx_pid == usb_pkg::SETUP);

   // Endpoint steering, only endp[0] matters past the token check
   assign ep_sel   = token.endp[0];
   assign in_empty = ep_sel ? epi_empty[1] : epi_empty[0];
   assign in_q     = ep_sel ? epi_q1 : epi_q0;
   assign epi_rd   = {in_rd & ep_sel, in_rd & ~ep_sel};
   assign stalled  = stall[ep_sel] && (token.pid != usb_pkg::SETUP);   // SETUP ignores halt

   always_comb
   begin
      tok_ok = (token.pidx == ~token.pid) &&
               usb_pkg::crc5_ok({token.crc5, token.endp, token.addr}) &&
               (token.addr == dev_addr) && (token.endp[3:1] == 3'd0);
      if (token.pid != usb_pkg::IN && token.endp[0])
         tok_ok = 1'b0;                   // Endpoint 1 is IN only
   end

   assign data_pid_ok = (rx.data[7:4] == ~rx.data[3:0]) &&
                        ((rx_pid == usb_pkg::DATA0) ||
                         (rx_pid == usb_pkg::DATA1 && token.pid != usb_pkg::SETUP));

   always_ff @(posedge clk)
   begin
      if (rst || usb_reset)
         state <= S_TOKEN0;
      else
         state <= state_next;
   end

   always_comb
   begin
      state_next = state;
      case (state)
         S_TOKEN0:
            if (rx.valid)
               state_next = tok_pid ? S_TOKEN1 : S_SKIP;
         S_TOKEN1:
            if (rx.valid)
               state_next = S_TOKEN2;
            else if (!rx.active)
               state_next = S_TOKEN0;     // Runt token
         S_TOKEN2:
            if (rx.valid)
               state_next = S_TOKEN3;
            else if (!rx.active)
               state_next = S_TOKEN0;
         S_TOKEN3:
            if (rx.valid)
               state_next = S_SKIP;       // Too long for a token
            else if (!rx.active)
            begin
               if (!tok_ok)
                  state_next = S_TOKEN0;
               else if (token.pid == usb_pkg::IN)
                  state_next = stalled ? S_STALL : S_IN_PID;
               else
                  state_next = S_OUT_PID;
            end
         S_SKIP:
            if (!rx.active)
               state_next = S_TOKEN0;
         S_OUT_PID:
            if (rx.valid)
               state_next = data_pid_ok ? S_OUT_DATA : S_SKIP;
         S_OUT_DATA:
            if (ep0o_wr && ep0o_full)
               state_next = S_SKIP;       // Overflow drops the packet
            else if (rx_end)
            begin
               if (!crc_good)
                  state_next = S_TOKEN0;
               else
                  state_next = stalled ? S_STALL : S_ACK;
            end
         S_IN_PID:
            if (tx_ready)
               state_next = in_empty ? S_IN_CRC0 : S_IN_DATA;
         S_IN_DATA:
            if (tx_ready && in_empty)
               state_next = S_IN_CRC0;
         S_IN_CRC0:
            if (tx_ready)
               state_next = S_IN_CRC1;
         S_IN_CRC1, S_ACK, S_STALL:
            if (tx_ready)
               state_next = S_TOKEN0;
         default:
            state_next = S_TOKEN0;
      endcase
   end

   // Token fields, CRC and the two-byte OUT delay line
   always_ff @(posedge clk)
   begin
      case (state)
         S_TOKEN0:
            if (rx.valid)
            begin
               token.pidx <= rx.data[7:4];
               token.pid  <= rx_pid;
            end
         S_TOKEN1:
            if (rx.valid)
            begin
               token.addr    <= rx.data[6:0];
               token.endp[0] <= rx.data[7];
            end
         S_TOKEN2:
            if (rx.valid)
            begin
               token.endp[3:1] <= rx.data[2:0];
               token.crc5      <= rx.data[7:3];
            end
         S_TOKEN3:
            crc <= 16'hffff;              // Preset for IN
         S_OUT_PID:
         begin
            crc  <= 16'hffff;             // Preset for OUT
            held <= 2'd0;
         end
         S_OUT_DATA:
            if (rx.valid)
            begin
               crc   <= usb_pkg::crc16_step(crc, rx.data);
               hold0 <= rx.data;
               hold1 <= hold0;
               if (held != 2'd2)
                  held <= held + 2'd1;
            end
         S_IN_DATA:
            if (tx_ready)
               crc <= usb_pkg::crc16_step(crc, in_q);
         default:
            ;
      endcase
   end

   // OUT bytes trail by two so the CRC16 bytes never reach the FIFO
   assign ep0o_wr     = (state == S_OUT_DATA) && rx.valid && (held == 2'd2);
   assign ep0o_din    = hold1;
   assign ep0o_commit = (state == S_OUT_DATA) && rx_end && crc_good && !stalled;
   assign ep0o_abort  = (state == S_OUT_DATA) &&
                        ((ep0o_wr && ep0o_full) || (rx_end && (!crc_good || stalled)));

   // Transmit mux
   always_comb
   begin
      tx.valid = 1'b0;
      tx.data  = 8'h00;
      in_rd    = 1'b0;
      case (state)
         S_IN_PID:
         begin
            tx.valid = 1'b1;
            tx.data  = {~usb_pkg::DATA0, usb_pkg::DATA0};
            in_rd    = tx_ready && !in_empty;   // Prefetch first byte
         end
         S_IN_DATA:
         begin
            tx.valid = 1'b1;
            tx.data  = in_q;              // Stable until rd
            in_rd    = tx_ready && !in_empty;
         end
         S_IN_CRC0:
         begin
            tx.valid = 1'b1;
            tx.data  = ~crc[7:0];         // Register already holds wire bit order
         end
         S_IN_CRC1:
         begin
            tx.valid = 1'b1;
            tx.data  = ~crc[15:8];
         end
         S_ACK:
         begin
            tx.valid = 1'b1;
            tx.data  = {~usb_pkg::ACK, usb_pkg::ACK};
         end
         S_STALL:
         begin
            tx.valid = 1'b1;
            tx.data  = {~usb_pkg::STALL, usb_pkg::STALL};
         end
         default:
            ;
      endcase
   end

endmodule

/* hdl/usb_device.sv */
`timescale 1ns/1ps

module usb_device #(
   parameter int EP_DEPTH = 64            // Bytes per endpoint FIFO
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              usb_reset,   // Bus reset from transceiver
   input  usb_pkg::utmi_rx_t rx,
   output usb_pkg::utmi_tx_t tx,
   input  logic              tx_ready,
   input  logic              cfg_req,
   input  usb_pkg::cfg_op_t  cfg_op,
   input  logic              cfg_ep,
   input  logic [6:0]        cfg_data,
   output logic              cfg_ack,
   input  logic              ep0_out_rd,
   output logic [7:0]        ep0_out_dout,
   output logic              ep0_out_empty,
   input  logic              ep0_in_wr,
   input  logic [7:0]        ep0_in_din,
   output logic              ep0_in_full,
   input  logic              ep1_in_wr,
   input  logic [7:0]        ep1_in_din,
   output logic              ep1_in_full
);

   logic [6:0] dev_addr;
   logic [1:0] stall;
   logic       ep0o_full;
   logic       ep0o_wr;
   logic       ep0o_commit;
   logic       ep0o_abort;
   logic [7:0] ep0o_din;
   logic [1:0] epi_empty;
   logic [7:0] epi_q0;
   logic [7:0] epi_q1;
   logic [1:0] epi_rd;

   usb_dev_regs usb_dev_regs_i (
      .clk(clk), .rst(rst), .usb_reset(usb_reset),
      .cfg_req(cfg_req), .cfg_op(cfg_op), .cfg_ep(cfg_ep), .cfg_data(cfg_data),
      .cfg_ack(cfg_ack), .dev_addr(dev_addr), .stall(stall)
   );

   usb_sie usb_sie_i (
      .clk(clk), .rst(rst), .usb_reset(usb_reset),
      .rx(rx), .tx(tx), .tx_ready(tx_ready),
      .dev_addr(dev_addr), .stall(stall),
      .ep0o_full(ep0o_full), .ep0o_wr(ep0o_wr), .ep0o_commit(ep0o_commit),
      .ep0o_abort(ep0o_abort), .ep0o_din(ep0o_din),
      .epi_empty(epi_empty), .epi_q0(epi_q0), .epi_q1(epi_q1), .epi_rd(epi_rd)
   );

   // OUT endpoint 0, written tentatively by the engine
   usb_endp_fifo #(.DEPTH(EP_DEPTH)) ep0_out_fifo_i (
      .clk(clk), .rst(rst), .clr(usb_reset),
      .wr(ep0o_wr), .commit(ep0o_commit), .abort(ep0o_abort), .din(ep0o_din),
      .rd(ep0_out_rd), .q(ep0_out_dout), .empty(ep0_out_empty), .full(ep0o_full)
   );

   // IN endpoints, host pushes are committed at once
   usb_endp_fifo #(.DEPTH(EP_DEPTH)) ep0_in_fifo_i (
      .clk(clk), .rst(rst), .clr(usb_reset),
      .wr(ep0_in_wr), .commit(1'b1), .abort(1'b0), .din(ep0_in_din),
      .rd(epi_rd[0]), .q(epi_q0), .empty(epi_empty[0]), .full(ep0_in_full)
   );

   usb_endp_fifo #(.DEPTH(EP_DEPTH)) ep1_in_fifo_i (
      .clk(clk), .rst(rst), .clr(usb_reset),
      .wr(ep1_in_wr), .commit(1'b1), .abort(1'b0), .din(ep1_in_din),
      .rd(epi_rd[1]), .q(epi_q1), .empty(epi_empty[1]), .full(ep1_in_full)
   );

endmodule

/* dv/usb_device_checker.sv */
`timescale 1ns/1ps

module usb_device_checker (
   input logic              clk,
   input logic              rst,
   input logic              usb_reset,
   input usb_pkg::utmi_tx_t tx,
   input logic              tx_ready,
   input logic              cfg_req,
   input logic              cfg_ack
);

   // Ack only ever answers a pending request
   ack_follows_req: assert property (@(posedge clk) disable iff (rst)
      $rose(cfg_ack) |-> $past(cfg_req))
      else $error("cfg_ack rose while cfg_req was low");

   // Byte frozen while the transceiver holds off
   tx_data_held: assert property (@(posedge clk) disable iff (rst)
      (tx.valid && !tx_ready && !usb_reset) |=> $stable(tx.data))
      else $error("tx.data changed while waiting for tx_ready");

   tx_idle_after_reset: assert property (@(posedge clk)
      (rst || usb_reset) |=> !tx.valid)
      else $error("tx.valid high in the cycle after reset");

endmodule

bind usb_device usb_device_checker usb_device_checker_i (
   .clk(clk), .rst(rst), .usb_reset(usb_reset), .tx(tx), .tx_ready(tx_ready),
   .cfg_req(cfg_req), .cfg_ack(cfg_ack)
);

/* dv/usb_device_tb.sv */
`timescale 1ns/1ps

module usb_device_tb;

   localparam int EP_DEPTH    = 64;
   localparam int TIMEOUT     = 400;      // Cycles allowed for any handshake
   localparam int RESP_WINDOW = 8;        // Response starts a cycle after rx ends

   logic              clk;
   logic              rst;
   logic              usb_reset;
   usb_pkg::utmi_rx_t rx;
   usb_pkg::utmi_tx_t tx;
   logic              tx_ready;
   logic              cfg_req;
   usb_pkg::cfg_op_t  cfg_op;
   logic              cfg_ep;
   logic [6:0]        cfg_data;
   logic              cfg_ack;
   logic              ep0_out_rd;
   logic [7:0]        ep0_out_dout;
   logic              ep0_out_empty;
   logic              ep0_in_wr;
   logic [7:0]        ep0_in_din;
   logic              ep0_in_full;
   logic              ep1_in_wr;
   logic [7:0]        ep1_in_din;
   logic              ep1_in_full;

   logic [7:0]  pkt[$];                   // Bytes of the next host packet
   logic [7:0]  payload[$];
   logic [7:0]  got[$];                   // Bytes seen from the DUT
   logic [7:0]  expected[$];
   logic [31:0] rng;
   string       test_name;
   int          errors;
   int          test_errors;
   int          tests;
   int          failed;

   usb_device #(.EP_DEPTH(EP_DEPTH)) usb_device_i (.*);

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;              // 250 MHz
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // x^5+x^2+1, shifted LSB first, sent inverted
   function automatic logic [4:0] crc5_calc(input logic [10:0] f);
      logic [4:0] c;
      logic       fb;
      c = 5'h1f;
      for (int i = 0; i < 11; i++)
      begin
         fb = c[0] ^ f[i];
         c  = c >> 1;
         if (fb)
            c = c ^ 5'h14;
      end
      return ~c;
   endfunction

   // x^16+x^15+x^2+1, one byte LSB first
   function automatic logic [15:0] crc16_byte(input logic [15:0] c, input logic [7:0] d);
      logic [15:0] r;
      logic        fb;
      r = c;
      for (int i = 0; i < 8; i++)
      begin
         fb = r[0] ^ d[i];
         r  = r >> 1;
         if (fb)
            r = r ^ 16'hA001;
      end
      return r;
   endfunction

   function automatic logic [7:0] pid_byte(input logic [3:0] pid);
      return {~pid, pid};
   endfunction

   task automatic begin_test(input string name);
      test_name   = name;
      test_errors = errors;
      tests++;
   endtask

   task automatic end_test();
      if (errors == test_errors)
         $display("%s: ok", test_name);
      else
      begin
         failed++;
         $display("%s: %0d errors", test_name, errors - test_errors);
      end
   endtask

   task automatic fill_payload(input int n);
      payload.delete();
      for (int i = 0; i < n; i++)
      begin
         rng = xorshift(rng);
         payload.push_back(rng[15:8]);
      end
   endtask

   task automatic token_packet(input logic [3:0] pid, input logic [6:0] addr,
                               input logic [3:0] endp, input logic bad_crc);
      logic [4:0] c;
      c = crc5_calc({endp, addr});
      if (bad_crc)
         c = c ^ 5'h01;                   // One flipped CRC bit
      pkt.delete();
      pkt.push_back(pid_byte(pid));
      pkt.push_back({endp[0], addr});
      pkt.push_back({c, endp[3:1]});
   endtask

   task automatic data_packet(input logic [3:0] pid, input logic corrupt);
      logic [15:0] c;
      c = 16'hffff;
      pkt.delete();
      pkt.push_back(pid_byte(pid));
      foreach (payload[i])
      begin
         pkt.push_back(payload[i]);
         c = crc16_byte(c, payload[i]);
      end
      pkt.push_back(~c[7:0]);
      pkt.push_back(~c[15:8]);
      if (corrupt)
         pkt[2] = pkt[2] ^ 8'h10;         // Damage after the CRC is fixed
   endtask

   task automatic send_pkt();
      foreach (pkt[i])
      begin
         @(posedge clk);
         rx.valid  <= 1'b1;
         rx.active <= 1'b1;
         rx.data   <= pkt[i];
      end
      @(posedge clk);
      rx <= '0;                           // End of packet
      @(posedge clk);
   endtask

   // Random tx_ready, records each byte taken until tx.valid drops
   task automatic collect_tx(input int window);
      int n;
      got.delete();
      n = 0;
      do
      begin
         @(negedge clk);
         n++;
      end
      while (!tx.valid && n < window);
      if (!tx.valid)
         return;                          // Silent
      n = 0;
      while (tx.valid && n < TIMEOUT)
      begin
         @(posedge clk);
         rng = xorshift(rng);
         tx_ready <= rng[0];
         @(negedge clk);
         if (tx.valid && tx_ready)
            got.push_back(tx.data);
         n++;
      end
      if (tx.valid)
      begin
         $display("%s: transmit packet did not end within %0d cycles", test_name, TIMEOUT);
         errors++;
      end
      @(posedge clk);
      tx_ready <= 1'b0;
   endtask

   task automatic config_op(input usb_pkg::cfg_op_t op, input logic ep, input logic [6:0] d);
      int n;
      @(posedge clk);
      cfg_op   <= op;
      cfg_ep   <= ep;
      cfg_data <= d;
      cfg_req  <= 1'b1;
      n = 0;
      do
      begin
         @(negedge clk);
         n++;
      end
      while (!cfg_ack && n < TIMEOUT);
      if (!cfg_ack)
      begin
         $display("%s: cfg_ack never rose", test_name);
         errors++;
      end
      @(posedge clk);
      cfg_req <= 1'b0;
      n = 0;
      do
      begin
         @(negedge clk);
         n++;
      end
      while (cfg_ack && n < TIMEOUT);
      if (cfg_ack)
      begin
         $display("%s: cfg_ack stuck high after cfg_req dropped", test_name);
         errors++;
      end
   endtask

   task automatic push_in(input logic ep);
      foreach (payload[i])
      begin
         @(posedge clk);
         if (ep)
         begin
            ep1_in_wr  <= 1'b1;
            ep1_in_din <= payload[i];
         end
         else
         begin
            ep0_in_wr  <= 1'b1;
            ep0_in_din <= payload[i];
         end
      end
      @(posedge clk);
      ep0_in_wr <= 1'b0;
      ep1_in_wr <= 1'b0;
   endtask

   task automatic drain_out();
      int n;
      got.delete();
      n = 0;
      @(negedge clk);
      while (!ep0_out_empty && n < EP_DEPTH)
      begin
         @(posedge clk);
         ep0_out_rd <= 1'b1;
         @(posedge clk);
         ep0_out_rd <= 1'b0;
         @(negedge clk);
         got.push_back(ep0_out_dout);     // Head shows a cycle after rd
         n++;
      end
      if (!ep0_out_empty)
      begin
         $display("Error %s, ep0_out_empty after %0d reads: expected 1, actual 0",
                  test_name, EP_DEPTH);
         errors++;
      end
   endtask

   task automatic compare_got(input string what);
      if (got.size() != expected.size())
      begin
         $display("Error %s, %s: expected %0d bytes, actual %0d bytes",
                  test_name, what, expected.size(), got.size());
         errors++;
      end
      else
      begin
         foreach (expected[i])
         begin
            if (got[i] !== expected[i])
            begin
               $display("Error %s, %s byte %0d: expected %h, actual %h",
                        test_name, what, i, expected[i], got[i]);
               errors++;
            end
         end
      end
   endtask

   // DATA0 PID, payload, inverted CRC16 low byte first
   task automatic expect_in_data();
      logic [15:0] c;
      c = 16'hffff;
      expected.delete();
      expected.push_back(pid_byte(usb_pkg::DATA0));
      foreach (payload[i])
      begin
         expected.push_back(payload[i]);
         c = crc16_byte(c, payload[i]);
      end
      expected.push_back(~c[7:0]);
      expected.push_back(~c[15:8]);
   endtask

   task automatic expect_silence(input string what);
      collect_tx(RESP_WINDOW);
      if (got.size() != 0)
      begin
         $display("Error %s, %s: expected 0 response bytes, actual %0d",
                  test_name, what, got.size());
         errors++;
      end
      if (!ep0_out_empty)
      begin
         $display("Error %s, %s ep0_out_empty: expected 1, actual 0", test_name, what);
         errors++;
      end
   endtask

   task automatic out_transfer();
      begin_test("OUT transfer");
      config_op(usb_pkg::CFG_SET_ADDR, 1'b0, 7'd5);
      fill_payload(6);
      token_packet(usb_pkg::OUT, 7'd5, 4'd0, 1'b0);
      send_pkt();
      data_packet(usb_pkg::DATA0, 1'b0);
      send_pkt();
      collect_tx(RESP_WINDOW);
      expected.delete();
      expected.push_back(pid_byte(usb_pkg::ACK));
      compare_got("handshake");
      drain_out();
      expected = payload;
      compare_got("ep0_out data");
      end_test();
   endtask

   task automatic rejected_packets();
      begin_test("Rejected packets");
      fill_payload(4);
      token_packet(usb_pkg::OUT, 7'd6, 4'd0, 1'b0);   // Another device
      send_pkt();
      data_packet(usb_pkg::DATA0, 1'b0);
      send_pkt();
      expect_silence("address 6");
      token_packet(usb_pkg::OUT, 7'd5, 4'd0, 1'b1);
      send_pkt();
      data_packet(usb_pkg::DATA0, 1'b0);
      send_pkt();
      expect_silence("bad CRC5");
      token_packet(usb_pkg::OUT, 7'd5, 4'd0, 1'b0);
      send_pkt();
      data_packet(usb_pkg::DATA0, 1'b1);              // CRC16 mismatch
      send_pkt();
      expect_silence("corrupted data");
      token_packet(usb_pkg::SETUP, 7'd5, 4'd0, 1'b0);
      send_pkt();
      data_packet(usb_pkg::DATA1, 1'b0);
      send_pkt();
      expect_silence("SETUP with DATA1");
      end_test();
   endtask

   task automatic in_transfer();
      begin_test("IN transfer");
      fill_payload(5);
      push_in(1'b1);
      token_packet(usb_pkg::IN, 7'd5, 4'd1, 1'b0);
      send_pkt();
      collect_tx(RESP_WINDOW);
      expect_in_data();
      compare_got("ep1 data");
      payload.delete();                   // FIFO now drained
      send_pkt();
      collect_tx(RESP_WINDOW);
      expect_in_data();
      compare_got("zero-length");
      end_test();
   endtask

   task automatic stall_handling();
      begin_test("Stall");
      config_op(usb_pkg::CFG_SET_STALL, 1'b1, 7'd0);
      fill_payload(3);
      push_in(1'b1);
      token_packet(usb_pkg::IN, 7'd5, 4'd1, 1'b0);
      send_pkt();
      collect_tx(RESP_WINDOW);
      expected.delete();
      expected.push_back(pid_byte(usb_pkg::STALL));
      compare_got("stalled IN");
      config_op(usb_pkg::CFG_CLR_STALL, 1'b1, 7'd0);
      send_pkt();
      collect_tx(RESP_WINDOW);
      expect_in_data();                   // Same bytes as before the stall
      compare_got("after clear");
      end_test();
   endtask

   task automatic bus_reset_recovery();
      begin_test("Bus reset");
      fill_payload(EP_DEPTH);
      push_in(1'b0);                      // Fill both IN FIFOs to the brim
      push_in(1'b1);
      @(negedge clk);
      if (!ep0_in_full || !ep1_in_full)
      begin
         $display("Error %s, IN full flags before reset: expected 11, actual %b%b",
                  test_name, ep1_in_full, ep0_in_full);
         errors++;
      end
      @(posedge clk);
      usb_reset <= 1'b1;
      @(posedge clk);
      usb_reset <= 1'b0;
      @(negedge clk);
      if (ep0_in_full || ep1_in_full)
      begin
         $display("Error %s, IN full flags after reset: expected 00, actual %b%b",
                  test_name, ep1_in_full, ep0_in_full);
         errors++;
      end
      token_packet(usb_pkg::IN, 7'd5, 4'd1, 1'b0);    // Old address
      send_pkt();
      expect_silence("old address 5");
      payload.delete();
      token_packet(usb_pkg::IN, 7'd0, 4'd1, 1'b0);
      send_pkt();
      collect_tx(RESP_WINDOW);
      expect_in_data();
      compare_got("ep1 after reset");
      token_packet(usb_pkg::IN, 7'd0, 4'd0, 1'b0);
      send_pkt();
      collect_tx(RESP_WINDOW);
      expect_in_data();
      compare_got("ep0 after reset");
      end_test();
   endtask

   initial
   begin
      rng        = 32'hd028;
      errors     = 0;
      tests      = 0;
      failed     = 0;
      rst        = 1'b1;
      usb_reset  = 1'b0;
      rx         = '0;
      tx_ready   = 1'b0;
      cfg_req    = 1'b0;
      cfg_op     = usb_pkg::CFG_SET_ADDR;
      cfg_ep     = 1'b0;
      cfg_data   = 7'd0;
      ep0_out_rd = 1'b0;
      ep0_in_wr  = 1'b0;
      ep0_in_din = 8'h00;
      ep1_in_wr  = 1'b0;
      ep1_in_din = 8'h00;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      out_transfer();
      rejected_packets();
      in_transfer();
      stall_handling();
      bus_reset_recovery();
      $display("%0d tests run, %0d failed, %0d errors", tests, failed, errors);
      if (errors == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

/* files.f */
hdl/usb_pkg.sv
hdl/usb_endp_fifo.sv
hdl/usb_dev_regs.sv
hdl/usb_sie.sv
hdl/usb_device.sv
dv/usb_device_checker.sv
dv/usb_device_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the usb_device testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
   --top-module usb_device_tb -f files.f -o usb_device_sim

./obj_dir/usb_device_sim 2>&1 | tee sim.log

if grep -q "Testbench passed" sim.log; then
   echo "Simulation result: pass"
   exit 0
else
   echo "Simulation result: fail"
   exit 1
fi
